/* run_sim.sh */
#!/bin/sh
# builds the stereo low-pass testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
	--top-module tb_stereo_lpf -o tb_stereo_lpf > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_stereo_lpf > sim.log 2>&1

grep -qx "Test OK" sim.log && echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }

/* sim/lpf_ref_model.svh */
`ifndef LPF_REF_MODEL_SVH
`define LPF_REF_MODEL_SVH

int ref_hist_left [`LPF_TAPS];   // index 0 holds the newest sample
int ref_hist_right [`LPF_TAPS];

// average length for a select value
function automatic int ref_length(input logic [2:0] sel);
	case (sel)
		3'd0: return 1;
		3'd1: return 2;
		3'd2: return 4;
		3'd3: return 8;
		3'd4: return 16;
		default: return 32;           // 5..7 all give the longest average
	endcase
endfunction

// rounds toward minus infinity, same as an arithmetic right shift
function automatic int ref_floor_div(input int x, input int len);
	if (x >= 0) begin
		return x / len;
	end else begin
		return -((-x + len - 1) / len);
	end
endfunction

function automatic void ref_clear();
	for (int k = 0; k < `LPF_TAPS; k++) begin
		ref_hist_left[k] = 0;
		ref_hist_right[k] = 0;
	end
endfunction

function automatic void ref_push(input int left, input int right);
	for (int k = `LPF_TAPS - 1; k > 0; k--) begin
		ref_hist_left[k] = ref_hist_left[k-1];
		ref_hist_right[k] = ref_hist_right[k-1];
	end
	ref_hist_left[0] = left;
	ref_hist_right[0] = right;
endfunction

// each tap divided by the length before summing
function automatic int ref_average(input logic [2:0] sel, input logic right_ch);
	int len;
	int sum;
	len = ref_length(sel);
	sum = 0;
	for (int k = 0; k < len; k++) begin
		sum += ref_floor_div(right_ch ? ref_hist_right[k] : ref_hist_left[k], len);
	end
	return sum;
endfunction

`endif

/* sim/tb_stereo_lpf.sv */
`timescale 1ns/1ps
`include "lpf_config.svh"

module tb_stereo_lpf;

	localparam int NUM_ROWS = 10;
	localparam int ACK_LIMIT = 8;     // cycles allowed for a Wishbone ack
	localparam int DRAIN_LIMIT = 16;  // cycles allowed for in-flight frames

	typedef struct packed {
		logic [2:0] filt_sel;
		logic       clear;
		logic [7:0] frames;
		logic [1:0] gap;              // idle cycles after each frame
	} row_t;

	logic                     clk;
	logic                     reset_n;
	lpf_pkg::wb_req_t         wb_req;
	lpf_pkg::wb_rsp_t         wb_rsp;
	lpf_pkg::stereo_frame_t   frame_in;
	lpf_pkg::stereo_frame_t   frame_out;

	row_t                     rows [NUM_ROWS];
	logic [2:0]               cur_sel;          // select the model averages with
	int                       total_frames;
	logic                     exp_valid [2];    // slot 0 is due at the next sample point
	logic [`LPF_SAMPLE_W-1:0] exp_left [2];
	logic [`LPF_SAMPLE_W-1:0] exp_right [2];

	`include "lpf_ref_model.svh"

	stereo_lpf_top dut (
		.clk       (clk),
		.reset_n   (reset_n),
		.wb_req    (wb_req),
		.wb_rsp    (wb_rsp),
		.frame_in  (frame_in),
		.frame_out (frame_out)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
			$display("Test FAILED");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout while waiting for %s", what);
		$display("Test FAILED");
		$fatal(1, "stopped on timeout");
	endtask

	// one clock: check the output frame due now, then drive the next input frame
	task automatic tick(input logic send, input logic signed [`LPF_SAMPLE_W-1:0] left,
		input logic signed [`LPF_SAMPLE_W-1:0] right);
		@(posedge clk);
		#1;
		check_value("frame_out.valid", 32'(frame_out.valid), 32'(exp_valid[0]));
		if (exp_valid[0]) begin
			check_value("frame_out.left", {8'h00, frame_out.left}, {8'h00, exp_left[0]});
			check_value("frame_out.right", {8'h00, frame_out.right}, {8'h00, exp_right[0]});
		end
		exp_valid[0] = exp_valid[1];
		exp_left[0]  = exp_left[1];
		exp_right[0] = exp_right[1];
		exp_valid[1] = send;
		if (send) begin
			ref_push(left, right);
			exp_left[1]  = `LPF_SAMPLE_W'(ref_average(cur_sel, 1'b0));
			exp_right[1] = `LPF_SAMPLE_W'(ref_average(cur_sel, 1'b1));
			total_frames++;
		end
		frame_in.valid = send;
		frame_in.left  = send ? left : '0;
		frame_in.right = send ? right : '0;
	endtask

	task automatic wb_access(input logic we, input logic [3:0] adr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		int   cycles;
		logic acked;
		cycles = 0;
		acked = 1'b0;
		wb_req.cyc   = 1'b1;
		wb_req.stb   = 1'b1;
		wb_req.we    = we;
		wb_req.adr   = adr;
		wb_req.dat_w = wdata;
		while (!acked && cycles < ACK_LIMIT) begin
			tick(1'b0, '0, '0);
			cycles++;
			acked = wb_rsp.ack;
		end
		if (!acked) begin
			report_timeout("Wishbone ack");
		end
		check_value("wb ack delay cycles", cycles, 32'd1);
		rdata = wb_rsp.dat_r;
		wb_req.cyc = 1'b0;
		wb_req.stb = 1'b0;
		wb_req.we  = 1'b0;
		tick(1'b0, '0, '0);
		check_value("wb_rsp.ack", 32'(wb_rsp.ack), 32'd0);   // single ack per request
	endtask

	task automatic wb_write(input logic [3:0] adr, input logic [31:0] data);
		logic [31:0] unused;
		wb_access(1'b1, adr, data, unused);
	endtask

	task automatic wb_read_check(input logic [3:0] adr, input logic [31:0] exp,
		input string name);
		logic [31:0] data;
		wb_access(1'b0, adr, 32'd0, data);
		check_value(name, data, exp);
	endtask

	// idles until every frame in flight has come out
	task automatic drain_stream();
		int cycles;
		cycles = 0;
		while ((exp_valid[0] || exp_valid[1]) && cycles < DRAIN_LIMIT) begin
			tick(1'b0, '0, '0);
			cycles++;
		end
		if (exp_valid[0] || exp_valid[1]) begin
			report_timeout("output frames to drain");
		end
	endtask

	task automatic run_row(input row_t row);
		logic signed [`LPF_SAMPLE_W-1:0] left;
		logic signed [`LPF_SAMPLE_W-1:0] right;
		drain_stream();
		wb_write(`LPF_REG_CTRL,
			32'(row.filt_sel) | (32'(row.clear) << `LPF_CTRL_CLEAR_BIT));
		cur_sel = row.filt_sel;
		if (row.clear) begin
			ref_clear();
		end
		wb_read_check(`LPF_REG_CTRL, 32'(row.filt_sel), "CTRL");   // clear bit reads 0
		for (int f = 0; f < int'(row.frames); f++) begin
			left  = `LPF_SAMPLE_W'($urandom());
			right = `LPF_SAMPLE_W'($urandom());
			tick(1'b1, left, right);
			for (int g = 0; g < int'(row.gap); g++) begin
				tick(1'b0, '0, '0);
			end
		end
	endtask

	initial begin
		void'($urandom(32'hb942_57f3));
		reset_n      = 1'b0;
		wb_req       = '0;
		frame_in     = '0;
		cur_sel      = '0;
		total_frames = 0;
		exp_valid[0] = 1'b0;
		exp_valid[1] = 1'b0;
		exp_left[0]  = '0;
		exp_left[1]  = '0;
		exp_right[0] = '0;
		exp_right[1] = '0;
		ref_clear();

		// filt_sel, clear, frames, gap
		rows[0] = {3'd0, 1'b0, 8'd6,  2'd0};
		rows[1] = {3'd1, 1'b0, 8'd10, 2'd1};
		rows[2] = {3'd2, 1'b0, 8'd12, 2'd0};
		rows[3] = {3'd3, 1'b1, 8'd12, 2'd2};
		rows[4] = {3'd4, 1'b0, 8'd20, 2'd0};
		rows[5] = {3'd5, 1'b0, 8'd36, 2'd0};
		rows[6] = {3'd6, 1'b1, 8'd20, 2'd1};
		rows[7] = {3'd7, 1'b0, 8'd36, 2'd0};
		rows[8] = {3'd2, 1'b1, 8'd8,  2'd0};
		rows[9] = {3'd0, 1'b0, 8'd4,  2'd3};

		repeat (5) @(posedge clk);
		#1;
		reset_n = 1'b1;

		wb_read_check(`LPF_REG_COUNT, 32'd0, "COUNT");
		wb_read_check(`LPF_REG_CTRL, 32'd0, "CTRL");

		for (int i = 0; i < NUM_ROWS; i++) begin
			run_row(rows[i]);
		end
		drain_stream();

		wb_read_check(`LPF_REG_COUNT, 32'(total_frames), "COUNT");
		wb_write(`LPF_REG_COUNT, 32'hdead_beef);     // read only, must be ignored
		wb_read_check(`LPF_REG_COUNT, 32'(total_frames), "COUNT");
		wb_read_check(4'h8, 32'd0, "unmapped 0x8");
		wb_read_check(4'hc, 32'd0, "unmapped 0xc");

		$display("Test OK");
		$finish;
	end

endmodule

/* source/lpf_config.svh */
`ifndef LPF_CONFIG_SVH
`define LPF_CONFIG_SVH

// audio sample and filter geometry
`define LPF_SAMPLE_W 24      // signed pcm sample width
`define LPF_TAPS 32          // delay line depth, longest average
`define LPF_SEL_W 3          // filter select width

// wishbone bus geometry
`define LPF_WB_ADR_W 4       // byte address, two words used
`define LPF_WB_DAT_W 32

// register byte offsets
`define LPF_REG_CTRL 4'h0    // filt_sel and history clear
`define LPF_REG_COUNT 4'h4   // output frame counter, read only

// CTRL register fields
`define LPF_CTRL_CLEAR_BIT 4 // write 1 to zero both delay lines

`endif

/* source/lpf_pkg.sv */
`include "lpf_config.svh"

package lpf_pkg;

	// one stereo sample period on the audio stream
	typedef struct packed {
		logic valid;
		logic signed [`LPF_SAMPLE_W-1:0] left;
		logic signed [`LPF_SAMPLE_W-1:0] right;
	} stereo_frame_t;

	// settings handed from the register block to both channel filters
	typedef struct packed {
		logic [`LPF_SEL_W-1:0] filt_sel; // 0..4 -> 1..16 taps, 5..7 -> 32 taps
		logic clear;                     // one cycle, zeroes the history
	} ctrl_t;

	// wishbone classic, master to slave
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [`LPF_WB_ADR_W-1:0] adr;
		logic [`LPF_WB_DAT_W-1:0] dat_w;
	} wb_req_t;

	// wishbone classic, slave to master
	typedef struct packed {
		logic ack;
		logic [`LPF_WB_DAT_W-1:0] dat_r;
	} wb_rsp_t;

endpackage

/* source/moving_avg_filter.sv */
`timescale 1ns/1ps
`include "lpf_config.svh"

module moving_avg_filter (
	input  logic                             clk,
	input  logic                             reset_n,
	input  logic                             sample_en,
	input  logic signed [`LPF_SAMPLE_W-1:0]  sample_in,
	input  lpf_pkg::ctrl_t                   ctrl,
	output logic signed [`LPF_SAMPLE_W-1:0]  sample_out,
	output logic                             out_valid
);

	localparam int SAMPLE_W  = `LPF_SAMPLE_W;
	localparam int TAPS      = `LPF_TAPS;
	localparam int SEL_W     = `LPF_SEL_W;
	localparam int MAX_SHIFT = $clog2(TAPS);          // log2 of the longest average
	localparam int ACC_W     = SAMPLE_W + MAX_SHIFT + 1;

	logic signed [SAMPLE_W-1:0] taps [TAPS];          // taps[0] is the newest sample
	logic [SEL_W-1:0]           shift;                // log2 of the active length
	logic signed [ACC_W-1:0]    acc;
	logic                       sum_en;               // sample shifted in last edge

	// selects above the longest length saturate to it
	always_comb begin
		if (ctrl.filt_sel > SEL_W'(MAX_SHIFT)) begin
			shift = SEL_W'(MAX_SHIFT);
		end else begin
			shift = ctrl.filt_sel;
		end
	end

	// delay line, stage 1
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int k = 0; k < TAPS; k++) begin
				taps[k] <= '0;
			end
		end else if (ctrl.clear) begin
			for (int k = 0; k < TAPS; k++) begin
				taps[k] <= '0;
			end
			if (sample_en) begin
				taps[0] <= sample_in;                  // a frame landing with the clear is kept
			end
		end else if (sample_en) begin
			taps[0] <= sample_in;
			for (int k = 1; k < TAPS; k++) begin
				taps[k] <= taps[k-1];
			end
		end
	end

	/*
	 * Each tap is divided by the length before it is added, so the sum of
	 * the truncated terms stays inside the sample range and needs no clamp.
	 * The rounding differs slightly from dividing the full sum.
	 */
	always_comb begin
		acc = '0;
		for (int k = 0; k < TAPS; k++) begin
			if (k < (1 << shift)) begin
				acc = acc + (taps[k] >>> shift);      // arithmetic shift keeps the sign
			end
		end
	end

	// valid pipeline
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			sum_en    <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			sum_en    <= sample_en;
			out_valid <= sum_en;
		end
	end

	// result register, stage 2
	always_ff @(posedge clk) begin
		if (sum_en) begin
			sample_out <= acc[SAMPLE_W-1:0];
		end
	end

	// two cycle latency from the stream strobe
	a_out_valid_latency: assert property (
		@(posedge clk) disable iff (!reset_n)
		out_valid |-> $past(sample_en, 2)
	);

endmodule

/* source/stereo_lpf_top.sv */
`timescale 1ns/1ps
`include "lpf_config.svh"

module stereo_lpf_top (
	input  logic                   clk,
	input  logic                   reset_n,
	input  lpf_pkg::wb_req_t       wb_req,
	output lpf_pkg::wb_rsp_t       wb_rsp,
	input  lpf_pkg::stereo_frame_t frame_in,
	output lpf_pkg::stereo_frame_t frame_out
);

	lpf_pkg::ctrl_t                 ctrl;         // shared by both channels
	logic signed [`LPF_SAMPLE_W-1:0] left_out;
	logic signed [`LPF_SAMPLE_W-1:0] right_out;
	logic                            left_valid;

	wb_ctrl_regs u_regs (
		.clk        (clk),
		.reset_n    (reset_n),
		.wb_req     (wb_req),
		.wb_rsp     (wb_rsp),
		.frame_done (left_valid),               // one count per stereo frame
		.ctrl       (ctrl)
	);

	moving_avg_filter u_left (
		.clk        (clk),
		.reset_n    (reset_n),
		.sample_en  (frame_in.valid),
		.sample_in  (frame_in.left),
		.ctrl       (ctrl),
		.sample_out (left_out),
		.out_valid  (left_valid)
	);

	// both channels run off one strobe, the left valid stands for the pair
	moving_avg_filter u_right (
		.clk        (clk),
		.reset_n    (reset_n),
		.sample_en  (frame_in.valid),
		.sample_in  (frame_in.right),
		.ctrl       (ctrl),
		.sample_out (right_out),
		.out_valid  ()
	);

	assign frame_out.valid = left_valid;
	assign frame_out.left  = left_out;
	assign frame_out.right = right_out;

endmodule

/* source/wb_ctrl_regs.sv */
`timescale 1ns/1ps
`include "lpf_config.svh"

module wb_ctrl_regs (
	input  logic              clk,
	input  logic              reset_n,
	input  lpf_pkg::wb_req_t  wb_req,
	output lpf_pkg::wb_rsp_t  wb_rsp,
	input  logic              frame_done,
	output lpf_pkg::ctrl_t    ctrl
);

	logic                      active;      // cyc and stb both high
	logic                      accept;      // request taken this cycle
	logic                      wr_ctrl;
	logic                      ack;
	logic [`LPF_WB_DAT_W-1:0]  dat_r;
	logic [`LPF_WB_DAT_W-1:0]  rd_data;
	logic [`LPF_SEL_W-1:0]     filt_sel;
	logic                      clear_arm;   // set with the ack of a clear write
	logic                      clear;
	logic [`LPF_WB_DAT_W-1:0]  frame_count;

	assign active  = wb_req.cyc && wb_req.stb;
	assign accept  = active && !ack;        // ack low in between, held request acks every other cycle
	assign wr_ctrl = accept && wb_req.we && (wb_req.adr == `LPF_REG_CTRL);

	// read mux, clear bit always reads back 0
	always_comb begin
		case (wb_req.adr)
			`LPF_REG_CTRL:  rd_data = `LPF_WB_DAT_W'(filt_sel);
			`LPF_REG_COUNT: rd_data = frame_count;
			default:        rd_data = '0;      // unmapped
		endcase
	end

	// bus handshake
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			ack <= 1'b0;
		end else begin
			ack <= accept;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			dat_r <= rd_data;                  // valid together with ack
		end
	end

	// control register and clear pulse
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			filt_sel  <= '0;
			clear_arm <= 1'b0;
			clear     <= 1'b0;
		end else begin
			if (wr_ctrl) begin
				filt_sel <= wb_req.dat_w[`LPF_SEL_W-1:0];
			end
			clear_arm <= wr_ctrl && wb_req.dat_w[`LPF_CTRL_CLEAR_BIT];
			clear     <= clear_arm;              // lands the cycle after the ack
		end
	end

	// output frame counter, writes to COUNT fall through the decode
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			frame_count <= '0;
		end else if (frame_done) begin
			frame_count <= frame_count + 1'b1;
		end
	end

	assign wb_rsp.ack   = ack;
	assign wb_rsp.dat_r = dat_r;

	assign ctrl.filt_sel = filt_sel;
	assign ctrl.clear    = clear;

	// every ack answers a request seen on the previous edge
	a_ack_needs_request: assert property (
		@(posedge clk) disable iff (!reset_n)
		ack |-> $past(wb_req.cyc && wb_req.stb)
	);

endmodule

/* verilog.f */
+incdir+source
+incdir+sim
source/lpf_pkg.sv
source/wb_ctrl_regs.sv
source/moving_avg_filter.sv
source/stereo_lpf_top.sv
sim/tb_stereo_lpf.sv
